/* Makefile */
# Verilator simulation of the vic bus core
SRCS := $(shell grep -v '^+' sim.f)

all: run

obj_dir/Vtb_vic: sim.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_vic -f sim.f

run: obj_dir/Vtb_vic
	./obj_dir/Vtb_vic

clean:
	rm -rf obj_dir

.PHONY: all run clean

/* bench/tb_vic.sv */
`timescale 1ns/1ps
`default_nettype none

// testbench for the vic bus core, checks by assertion
module tb_vic;
        import vic_pkg::*;

        localparam int MAX_CYCLES  = 40000;     // about 8 lines of 2080 clks, plus margin
        localparam int LINES_APART = 2;         // raster step test span

        logic        clk_dot4x;
        logic        arst_n;
        logic        ce;
        logic        rw;
        logic [5:0]  adi;
        logic [7:0]  dbi;
        logic        lp;
        logic [7:0]  dbo;
        logic        db_oe;
        logic [11:0] ado;
        logic        ab_oe;
        logic        phi;
        logic        aec;
        logic        ba;
        logic        irq;
        logic        live;              // pads settled after reset
        logic        pen_phase;         // only the masked pen source remains
        logic        phi_q;             // phi one clock back
        int          half_clk;          // clocks since phi last changed
        integer      seed;
        int          cycles;

        vic_bus DUT (
                .clk_dot4x(clk_dot4x), .arst_n(arst_n), .ce(ce), .rw(rw), .adi(adi),
                .dbi(dbi), .lp(lp), .dbo(dbo), .db_oe(db_oe), .ado(ado), .ab_oe(ab_oe),
                .phi(phi), .aec(aec), .ba(ba), .irq(irq)
        );

        initial begin
                clk_dot4x = 1'b0;
                forever #20 clk_dot4x = ~clk_dot4x;     // 40 ns period
        end

        task automatic abort_run(input string msg);
                $display("%s", msg);
                $display("sim failed");
                $fatal(1);
        endtask

        task automatic check_value(input string what, input logic [7:0] got,
                                   input logic [7:0] exp);
                assert (got === exp)
                else abort_run($sformatf("** Error at %0t: %s is %02h, expected %02h",
                                         $time, what, got, exp));
        endtask

        // one cpu write in the next phi high half
        task automatic bus_write(input logic [5:0] addr, input logic [7:0] data);
                @(posedge phi);
                @(posedge clk_dot4x);
                ce  <= 1'b0;
                rw  <= 1'b0;
                adi <= addr;
                dbi <= data;
                @(negedge phi);         // bus released as phi drops
                ce  <= 1'b1;
                rw  <= 1'b1;
        endtask

        // one cpu read, data taken while db_oe is up
        task automatic bus_read(input logic [5:0] addr, output logic [7:0] data);
                @(posedge phi);
                @(posedge clk_dot4x);
                ce  <= 1'b0;
                rw  <= 1'b1;
                adi <= addr;
                @(negedge clk_dot4x);
                while (!db_oe && phi)
                        @(negedge clk_dot4x);
                if (!db_oe)
                        abort_run("read got no data on dbo before phi fell");
                data = dbo;
                @(negedge phi);
                ce <= 1'b1;
        endtask

        // lp low for a few clks, falling edge is what counts
        task automatic pulse_pen();
                lp <= 1'b0;
                repeat (8) @(posedge clk_dot4x);
                lp <= 1'b1;
        endtask

        always @(posedge clk_dot4x) begin
                cycles <= cycles + 1;
                if (cycles == MAX_CYCLES)
                        abort_run($sformatf("timeout, run not done after %0d clocks", MAX_CYCLES));
        end

        // position inside the current phi half
        always @(posedge clk_dot4x) begin
                phi_q <= phi;
                if (!arst_n)
                        half_clk <= 0;
                else if (phi != phi_q)
                        half_clk <= 1;
                else
                        half_clk <= half_clk + 1;
        end

        // each phi half lasts PHI_HALF clocks
        a_phi_period: assert property (@(posedge clk_dot4x) disable iff (!live)
                phi != phi_q |-> half_clk == PHI_HALF)
                else abort_run($sformatf("** Error at %0t: phi half is not %0d clocks",
                                         $time, PHI_HALF));

        // data bus only after the sample point of a read, up to the fall of phi
        a_db_window: assert property (@(posedge clk_dot4x) disable iff (!live)
                db_oe == (phi && phi_q && !ce && rw && half_clk > CPU_SAMPLE))
                else abort_run($sformatf("** Error at %0t: db_oe wrong for the read window",
                                         $time));

        // vic owns the address bus exactly in phi low
        a_ab_phase: assert property (@(posedge clk_dot4x) disable iff (!live)
                ab_oe == !phi && aec == phi && ado[11:8] == 4'hf)
                else abort_run($sformatf("** Error at %0t: ab_oe/aec wrong for phi", $time));

        // refresh row steps down by one as phi falls, holds otherwise
        a_ref_step: assert property (@(posedge clk_dot4x) disable iff (!live)
                ado[7:0] == ((phi_q && !phi) ? $past(ado[7:0]) - 8'd1 : $past(ado[7:0])))
                else abort_run($sformatf("** Error at %0t: refresh address step wrong",
                                         $time));

        a_ba_high: assert property (@(posedge clk_dot4x) disable iff (!arst_n) ba)
                else abort_run($sformatf("** Error at %0t: ba went low", $time));

        a_pen_masked: assert property (@(posedge clk_dot4x) disable iff (!arst_n)
                pen_phase |-> irq)
                else abort_run($sformatf("** Error at %0t: irq low from masked pen", $time));

        initial begin
                logic [7:0] val;
                logic [7:0] rd;
                logic [7:0] line_a;
                logic [7:0] line_b;
                seed      = 61080;
                cycles    = 0;
                arst_n    = 1'b0;
                ce        = 1'b1;
                rw        = 1'b1;
                adi       = '0;
                dbi       = '0;
                lp        = 1'b1;
                live      = 1'b0;
                pen_phase = 1'b0;
                repeat (15) @(posedge clk_dot4x);
                @(negedge clk_dot4x);
                check_value("irq in reset", {7'd0, irq}, 8'h01);
                check_value("db_oe in reset", {7'd0, db_oe}, 8'h00);
                check_value("ab_oe in reset", {7'd0, ab_oe}, 8'h00);
                @(posedge clk_dot4x);
                arst_n <= 1'b1;
                repeat (2) @(posedge clk_dot4x);
                live <= 1'b1;

                // colour registers hold a nibble, upper bits read high
                repeat (2) begin
                        val = 8'($random(seed));
                        bus_write(REG_BORDER, val);
                        bus_read(REG_BORDER, rd);
                        check_value("border", rd, {4'hf, val[3:0]});
                        val = 8'($random(seed));
                        bus_write(REG_BG0, val);
                        bus_read(REG_BG0, rd);
                        check_value("bg0", rd, {4'hf, val[3:0]});
                end
                bus_read(6'h3f, rd);
                check_value("unused address", rd, 8'hff);

                // 65 phi cycles per line
                bus_read(REG_RASTER, line_a);
                repeat (LINES_APART * CYCLES_PER_LINE - 1) @(posedge phi);
                bus_read(REG_RASTER, line_b);
                check_value("raster step", line_b, line_a + 8'(LINES_APART));
                bus_read(REG_CTRL1, rd);
                check_value("ctrl1", rd, 8'h00);        // line below 256, nothing stored

                // raster compare on line 5
                bus_write(REG_RASTER, 8'd5);
                bus_write(REG_IRQ_EN, 8'h01 << IRQ_RASTER);
                check_value("irq before line 5", {7'd0, irq}, 8'h01);
                @(negedge irq);
                bus_read(REG_RASTER, rd);
                check_value("line at raster irq", rd, 8'd5);
                bus_read(REG_IRQ, rd);
                check_value("irq status", rd, 8'hf1);   // pending, 3 ones, raster
                bus_write(REG_IRQ, 8'h01);
                @(negedge clk_dot4x);
                check_value("irq after clear", {7'd0, irq}, 8'h01);
                bus_read(REG_IRQ, rd);
                check_value("irq status after clear", rd, 8'h70);

                // line 7 start is known from the raster irq
                bus_write(REG_RASTER, 8'd7);
                @(negedge irq);
                pulse_pen();
                bus_write(REG_IRQ, 8'h01);              // drop raster, pen stays
                @(negedge clk_dot4x);
                check_value("irq with pen only", {7'd0, irq}, 8'h01);
                pen_phase <= 1'b1;
                bus_read(REG_LPY, rd);
                check_value("light pen y", rd, 8'd7 >> 1);
                bus_read(REG_LPX, rd);
                check_value("light pen x", rd, 8'd0);   // cycle 0 times 4
                bus_read(REG_IRQ, rd);
                check_value("irq status with pen", rd, 8'h78);
                pen_phase <= 1'b0;

                // line 8 would latch a different y, same frame so it must be ignored
                bus_write(REG_RASTER, 8'd8);
                @(negedge irq);
                pulse_pen();
                repeat (8) @(posedge clk_dot4x);
                bus_read(REG_LPY, rd);
                check_value("light pen y after second pulse", rd, 8'd7 >> 1);
                $display("sim passed");
                $finish;
        end

endmodule : tb_vic

`default_nettype wire

/* common/vic_pkg.sv */
`default_nettype none

package vic_pkg;

        // phi timing, counted in clk_dot4x cycles
        localparam int PHI_DIV    = 32;         // one full phi cycle
        localparam int PHI_HALF   = 16;         // phi low half, then high half
        localparam int CPU_SAMPLE = 12;         // cpu access taken here in the high half

        // 6567R8 raster geometry
        localparam int CYCLES_PER_LINE = 65;
        localparam int LINES_PER_FRAME = 263;

        // register map (6 bit cpu address)
        localparam logic [5:0] REG_CTRL1  = 6'h11;      // ctrl1, bit 7 is raster bit 8
        localparam logic [5:0] REG_RASTER = 6'h12;
        localparam logic [5:0] REG_LPX    = 6'h13;      // light pen x, read only
        localparam logic [5:0] REG_LPY    = 6'h14;      // light pen y, read only
        localparam logic [5:0] REG_IRQ    = 6'h19;      // status, write 1 to clear
        localparam logic [5:0] REG_IRQ_EN = 6'h1A;
        localparam logic [5:0] REG_BORDER = 6'h20;
        localparam logic [5:0] REG_BG0    = 6'h21;

        // bit positions in irq status and enable
        localparam int IRQ_RASTER = 0;
        localparam int IRQ_LPEN   = 3;

        // one cpu access, valid while cpu_stb is high
        typedef struct packed {
                logic [5:0] addr;
                logic [7:0] wdata;
                logic       write;      // rw was low
        } cpu_req_t;

        // beam position plus the edge markers
        typedef struct packed {
                logic [8:0] line;
                logic [6:0] cycle;
                logic       line_start;         // first clk of a new line
                logic       frame_start;        // first clk of line 0
        } raster_t;

        // single cycle source pulses into the irq unit
        typedef struct packed {
                logic raster_hit;
                logic lpen_hit;
        } irq_src_t;

endpackage : vic_pkg

`default_nettype wire

/* rtl/irq_unit.sv */
`timescale 1ns/1ps
`default_nettype none

// interrupt latch, enable mask and irq pin
module irq_unit (
        input  wire                 clk_dot4x,
        input  wire                 arst_n,
        input  vic_pkg::raster_t    raster,
        input  wire  [8:0]          cmp_line,
        input  wire                 lpen_hit,
        input  wire  [7:0]          irq_en,
        input  wire  [7:0]          irq_clr,    // 1 bits clear status
        output logic [7:0]          irq_status,
        output logic                irq_pending,
        output logic                irq
);
        import vic_pkg::*;

        irq_src_t   src;
        logic [7:0] set_bits;

        // raster compare only counts at the start of the line
        always_comb begin
                src.raster_hit = raster.line_start && (raster.line == cmp_line);
                src.lpen_hit   = lpen_hit;
        end

        always_comb begin
                set_bits             = '0;
                set_bits[IRQ_RASTER] = src.raster_hit;
                set_bits[IRQ_LPEN]   = src.lpen_hit;
        end

        // sticky, a new source wins over a clear in the same cycle
        always_ff @(posedge clk_dot4x or negedge arst_n) begin
                if (!arst_n) begin
                        irq_status <= '0;
                end else begin
                        irq_status <= (irq_status & ~irq_clr) | set_bits;
                end
        end

        assign irq_pending = |(irq_status & irq_en);
        assign irq         = !irq_pending;      // open drain style, low = active

        // once low, irq only lets go after a clear or an enable write
        a_irq_hold: assert property (@(posedge clk_dot4x) disable iff (!arst_n)
                !irq && irq_clr == 8'h00 |=> !irq || irq_en != $past(irq_en));

        // a cpu clear must stick unless the raster hits again right then
        a_clr_raster: assert property (@(posedge clk_dot4x) disable iff (!arst_n)
                irq_clr[IRQ_RASTER] && !src.raster_hit |=> !irq_status[IRQ_RASTER]);

endmodule : irq_unit

`default_nettype wire

/* rtl/phase_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

// phi divider and bus phase control
// phi low half belongs to the vic (refresh), high half to the cpu
module phase_sequencer (
        input  wire                   clk_dot4x,
        input  wire                   arst_n,
        input  wire                   ce,       // chip enable, active low
        input  wire                   rw,       // high = read
        input  wire  [5:0]            adi,
        input  wire  [7:0]            dbi,
        output logic                  phi,
        output logic                  aec,
        output logic                  cpu_stb,
        output logic                  phi_end,
        output vic_pkg::cpu_req_t     req,
        output logic [7:0]            ref_addr
);
        import vic_pkg::*;

        logic [4:0] phase;      // position inside the phi cycle
        logic       sample_pt;  // clk before the cpu sample point

        always_ff @(posedge clk_dot4x or negedge arst_n) begin
                if (!arst_n) begin
                        phase <= '0;
                end else begin
                        phase <= phase + 5'd1;  // wraps at PHI_DIV
                end
        end

        assign phi       = (phase >= 5'(PHI_HALF));     // low first after reset
        assign phi_end   = (phase == 5'(PHI_DIV - 1));
        assign aec       = phi;         // no badlines, so cpu always owns the high half
        assign sample_pt = (phase == 5'(PHI_HALF + CPU_SAMPLE - 1));

        // strobe lands on cycle CPU_SAMPLE of the high half, aligned with req
        always_ff @(posedge clk_dot4x or negedge arst_n) begin
                if (!arst_n) begin
                        cpu_stb <= 1'b0;
                end else begin
                        cpu_stb <= sample_pt && !ce;
                end
        end

        // bus lines have settled by now
        always_ff @(posedge clk_dot4x) begin
                if (sample_pt) begin
                        req.addr  <= adi;
                        req.wdata <= dbi;
                        req.write <= !rw;
                end
        end

        // dram refresh row, counts down once per phi
        always_ff @(posedge clk_dot4x or negedge arst_n) begin
                if (!arst_n) begin
                        ref_addr <= 8'hff;
                end else if (phi_end) begin
                        ref_addr <= ref_addr - 8'd1;
                end
        end

        // the cpu only ever gets the bus in the phi high half
        a_stb_in_high: assert property (@(posedge clk_dot4x) disable iff (!arst_n)
                cpu_stb |-> phi);

endmodule : phase_sequencer

`default_nettype wire

/* rtl/raster_counter.sv */
`timescale 1ns/1ps
`default_nettype none

// beam position for 6567R8, 65 cycles x 263 lines
module raster_counter (
        input  wire                 clk_dot4x,
        input  wire                 arst_n,
        input  wire                 phi_end,    // advance one phi cycle
        output vic_pkg::raster_t    raster
);
        import vic_pkg::*;

        logic last_cycle;
        logic last_line;

        assign last_cycle = (raster.cycle == 7'(CYCLES_PER_LINE - 1));
        assign last_line  = (raster.line == 9'(LINES_PER_FRAME - 1));

        always_ff @(posedge clk_dot4x or negedge arst_n) begin
                if (!arst_n) begin
                        raster <= '0;   // line 0, cycle 0
                end else begin
                        raster.line_start  <= 1'b0;
                        raster.frame_start <= 1'b0;
                        if (phi_end) begin
                                if (last_cycle) begin
                                        raster.cycle      <= '0;
                                        raster.line_start <= 1'b1;      // same edge as line step
                                        if (last_line) begin
                                                raster.line        <= '0;
                                                raster.frame_start <= 1'b1;
                                        end else begin
                                                raster.line <= raster.line + 9'd1;
                                        end
                                end else begin
                                        raster.cycle <= raster.cycle + 7'd1;
                                end
                        end
                end
        end

        a_line_range: assert property (@(posedge clk_dot4x) disable iff (!arst_n)
                raster.line < 9'(LINES_PER_FRAME));

        // a frame marker only ever comes with line 0 at its start
        a_frame_mark: assert property (@(posedge clk_dot4x) disable iff (!arst_n)
                raster.frame_start |-> raster.line_start && raster.line == '0);

endmodule : raster_counter

`default_nettype wire

/* rtl/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

// cpu visible registers, read mux and light pen latch
module register_file (
        input  wire                 clk_dot4x,
        input  wire                 arst_n,
        input  wire                 cpu_stb,
        input  vic_pkg::cpu_req_t   req,
        input  vic_pkg::raster_t    raster,
        input  wire                 lp,         // light pen, falling edge
        input  wire  [7:0]          irq_status,
        input  wire                 irq_pending,
        output logic [7:0]          rdata,
        output logic [8:0]          cmp_line,
        output logic [7:0]          irq_en,
        output logic [7:0]          irq_clr,
        output logic                lpen_hit
);
        import vic_pkg::*;

        logic [6:0] ctrl1;      // bit 7 lives in cmp_line[8]
        logic [3:0] border;
        logic [3:0] bg0;
        logic [7:0] lpx;
        logic [7:0] lpy;
        logic [2:0] lp_q;       // two sync flops plus edge history
        logic       lp_fall;
        logic       lp_locked;  // one latch per frame
        logic       wr_stb;
        logic [7:0] rd_mux;

        assign wr_stb = cpu_stb && req.write;

        // clear pulse goes straight to the irq unit, lands with the write
        assign irq_clr = (wr_stb && req.addr == REG_IRQ) ? req.wdata : 8'h00;

        always_ff @(posedge clk_dot4x or negedge arst_n) begin
                if (!arst_n) begin
                        ctrl1    <= '0;
                        cmp_line <= '0;
                        irq_en   <= '0;
                        border   <= '0;
                        bg0      <= '0;
                end else if (wr_stb) begin
                        case (req.addr)
                        REG_CTRL1: begin
                                ctrl1       <= req.wdata[6:0];
                                cmp_line[8] <= req.wdata[7];
                        end
                        REG_RASTER: cmp_line[7:0] <= req.wdata;
                        REG_IRQ_EN: irq_en        <= {4'h0, req.wdata[3:0]};
                        REG_BORDER: border        <= req.wdata[3:0];
                        REG_BG0:    bg0           <= req.wdata[3:0];
                        default: ;              // read only or unmapped
                        endcase
                end
        end

        // unused bits float high, as on the real part
        always_comb begin
                case (req.addr)
                REG_CTRL1:  rd_mux = {raster.line[8], ctrl1};
                REG_RASTER: rd_mux = raster.line[7:0];
                REG_LPX:    rd_mux = lpx;
                REG_LPY:    rd_mux = lpy;
                REG_IRQ:    rd_mux = {irq_pending, 3'b111, irq_status[3:0]};
                REG_IRQ_EN: rd_mux = {4'hf, irq_en[3:0]};
                REG_BORDER: rd_mux = {4'hf, border};
                REG_BG0:    rd_mux = {4'hf, bg0};
                default:    rd_mux = 8'hff;
                endcase
        end

        always_ff @(posedge clk_dot4x or negedge arst_n) begin
                if (!arst_n) begin
                        rdata <= '0;
                end else if (cpu_stb && !req.write) begin
                        rdata <= rd_mux;        // held for the rest of phi high
                end
        end

        // light pen input is asynchronous
        always_ff @(posedge clk_dot4x or negedge arst_n) begin
                if (!arst_n) begin
                        lp_q <= 3'b111;         // idle high
                end else begin
                        lp_q <= {lp_q[1:0], lp};
                end
        end

        assign lp_fall = lp_q[2] && !lp_q[1];

        always_ff @(posedge clk_dot4x or negedge arst_n) begin
                if (!arst_n) begin
                        lpx       <= '0;
                        lpy       <= '0;
                        lp_locked <= 1'b0;
                        lpen_hit  <= 1'b0;
                end else begin
                        lpen_hit <= 1'b0;
                        if (raster.frame_start)
                                lp_locked <= 1'b0;      // re-arm each frame
                        if (lp_fall && !lp_locked) begin
                                lpx       <= {raster.cycle[5:0], 2'b00};       // cycle x 4
                                lpy       <= raster.line[8:1];
                                lp_locked <= 1'b1;
                                lpen_hit  <= 1'b1;
                        end
                end
        end

        // at most one latch between frame starts
        a_lp_once: assert property (@(posedge clk_dot4x) disable iff (!arst_n)
                lpen_hit && !raster.frame_start |=> (!lpen_hit until raster.frame_start));

endmodule : register_file

`default_nettype wire

/* rtl/vic_bus.sv */
`timescale 1ns/1ps
`default_nettype none

// bus side core, pad tri-states live in the board top
module vic_bus (
        input  wire         clk_dot4x,
        input  wire         arst_n,
        input  wire         ce,         // chip enable, active low
        input  wire         rw,         // high = read
        input  wire  [5:0]  adi,
        input  wire  [7:0]  dbi,
        input  wire         lp,
        output logic [7:0]  dbo,
        output logic        db_oe,      // vic drives data bus
        output logic [11:0] ado,
        output logic        ab_oe,      // vic drives address bus
        output logic        phi,
        output logic        aec,
        output logic        ba,
        output logic        irq
);
        import vic_pkg::*;

        logic       cpu_stb;
        logic       phi_end;
        cpu_req_t   req;
        logic [7:0] ref_addr;
        raster_t    raster;
        logic [7:0] rdata;
        logic [8:0] cmp_line;
        logic [7:0] irq_en;
        logic [7:0] irq_clr;
        logic       lpen_hit;
        logic [7:0] irq_status;
        logic       irq_pending;
        logic       rd_valid;   // read data sits in rdata
        logic       bus_live;   // pads stay released until out of reset

        phase_sequencer u_phase (
                .clk_dot4x(clk_dot4x), .arst_n(arst_n), .ce(ce), .rw(rw),
                .adi(adi), .dbi(dbi), .phi(phi), .aec(aec), .cpu_stb(cpu_stb),
                .phi_end(phi_end), .req(req), .ref_addr(ref_addr)
        );

        raster_counter u_raster (
                .clk_dot4x(clk_dot4x), .arst_n(arst_n), .phi_end(phi_end),
                .raster(raster)
        );

        register_file u_regs (
                .clk_dot4x(clk_dot4x), .arst_n(arst_n), .cpu_stb(cpu_stb),
                .req(req), .raster(raster), .lp(lp), .irq_status(irq_status),
                .irq_pending(irq_pending), .rdata(rdata), .cmp_line(cmp_line),
                .irq_en(irq_en), .irq_clr(irq_clr), .lpen_hit(lpen_hit)
        );

        irq_unit u_irq (
                .clk_dot4x(clk_dot4x), .arst_n(arst_n), .raster(raster),
                .cmp_line(cmp_line), .lpen_hit(lpen_hit), .irq_en(irq_en),
                .irq_clr(irq_clr), .irq_status(irq_status),
                .irq_pending(irq_pending), .irq(irq)
        );

        // set with the read strobe, dropped as phi falls
        always_ff @(posedge clk_dot4x or negedge arst_n) begin
                if (!arst_n) begin
                        rd_valid <= 1'b0;
                        bus_live <= 1'b0;
                end else begin
                        bus_live <= 1'b1;
                        if (phi_end)
                                rd_valid <= 1'b0;
                        else if (cpu_stb && !req.write)
                                rd_valid <= 1'b1;
                end
        end

        assign dbo   = rdata;
        assign db_oe = rd_valid && !ce && rw;   // cpu still reading
        assign ado   = {4'hf, ref_addr};        // refresh row, upper lines high
        assign ab_oe = bus_live && !aec;        // vic owns the bus in phi low
        assign ba    = 1'b1;                    // no badlines, never stall the cpu

        // data and address drivers must never overlap on the board
        a_no_overlap: assert property (@(posedge clk_dot4x) disable iff (!arst_n)
                !(db_oe && ab_oe));

endmodule : vic_bus

`default_nettype wire

/* sim.f */
common/vic_pkg.sv
rtl/phase_sequencer.sv
rtl/raster_counter.sv
rtl/irq_unit.sv
rtl/register_file.sv
rtl/vic_bus.sv
bench/tb_vic.sv
